// File: cpu_pkg.sv
/* Widths, ISA encoding, AXI4-Lite channel types and register map for the 16-bit core
   Program space is 128 words; unlisted opcodes execute as nop */
package cpu_pkg;

  localparam int addr_w     = 7;
  localparam int inst_w     = 16;
  localparam int data_w     = 16;
  localparam int num_regs   = 8;
  localparam int sel_w      = $clog2(num_regs);
  localparam int imem_depth = 1 << addr_w;

  localparam int axi_addr_w = 8;
  localparam int axi_data_w = 32;

  // Opcode sits in inst[15:12], rd in [11:9], rs in [8:6]
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ldi  = 4'h1,  // rd <= zero-extended inst[8:0]
    op_add  = 4'h2,
    op_sub  = 4'h3,
    op_and  = 4'h4,
    op_or   = 4'h5,
    op_xor  = 4'h6,
    op_jmp  = 4'h7,  // Target in inst[6:0]
    op_bz   = 4'h8,  // Taken when rd is zero
    op_halt = 4'hf
  } opcode_t;

  // Host-driven channels
  typedef struct packed {
    logic [axi_addr_w-1:0] awaddr;
    logic                  awvalid;
    logic [axi_data_w-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  bready;
    logic [axi_addr_w-1:0] araddr;
    logic                  arvalid;
    logic                  rready;
  } axi_lite_req_t;

  // Slave-driven channels
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic [axi_data_w-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
  } axi_lite_rsp_t;

  localparam logic [1:0] resp_okay = 2'b00;

  // Register map, byte offsets
  localparam logic [axi_addr_w-1:0] reg_ctrl_ofs      = 8'h00;
  localparam logic [axi_addr_w-1:0] reg_status_ofs    = 8'h04;
  localparam logic [axi_addr_w-1:0] reg_imem_addr_ofs = 8'h08;
  localparam logic [axi_addr_w-1:0] reg_imem_data_ofs = 8'h0c;
  localparam logic [axi_addr_w-1:0] reg_gpr_base_ofs  = 8'h10;
  localparam logic [axi_addr_w-1:0] reg_gpr_last_ofs  = 8'h2c;

  // Position of halt_pc inside STATUS
  localparam int halt_pc_lsb = 8;

endpackage

// File: axi_lite_regs.sv
/* AXI4-Lite register block; wstrb is ignored and every response is OKAY
   Unmapped reads return 0; IMEM_DATA writes are dropped while the core runs */
module axi_lite_regs
  import cpu_pkg::*;
(
  input  logic                clk_n,
  input  logic                reset,
  input  axi_lite_req_t       axi_req,
  output axi_lite_rsp_t       axi_rsp,
  input  logic                halt_event,
  input  logic [addr_w-1:0]   halt_pc,
  input  logic [data_w-1:0]   gpr_data,
  output logic                run,
  output logic                imem_we,
  output logic [addr_w-1:0]   imem_waddr,
  output logic [inst_w-1:0]   imem_wdata,
  output logic [sel_w-1:0]    gpr_sel
);

  logic                  aw_ready;  // Shared by AW and W
  logic                  b_valid;
  logic                  ar_ready;
  logic                  r_valid;
  logic [axi_data_w-1:0] r_data;
  logic                  halted;
  logic [addr_w-1:0]     halt_pc_q;
  logic [addr_w-1:0]     load_addr;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  gpr_hit;
  logic [axi_addr_w-1:0] gpr_ofs;
  logic [axi_data_w-1:0] rd_mux;

  assign wr_fire = aw_ready && axi_req.awvalid && axi_req.wvalid;
  assign rd_fire = ar_ready && axi_req.arvalid;

  // Write handshake, one transaction in flight
  always_ff @(posedge clk_n) begin
    if (reset) begin
      aw_ready <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      aw_ready <= axi_req.awvalid && axi_req.wvalid && !b_valid && !aw_ready;
      if (wr_fire)
        b_valid <= 1'b1;
      else if (axi_req.bready)
        b_valid <= 1'b0;
    end
  end

  // Control and status state
  always_ff @(posedge clk_n) begin
    if (reset) begin
      run       <= 1'b0;
      halted    <= 1'b0;
      halt_pc_q <= '0;
      load_addr <= '0;
      imem_we   <= 1'b0;
    end else begin
      imem_we <= 1'b0;
      if (wr_fire) begin
        case (axi_req.awaddr)
          reg_ctrl_ofs: begin
            run <= axi_req.wdata[0];
            if (axi_req.wdata[0])
              halted <= 1'b0;  // New run clears the old halt
          end
          reg_imem_addr_ofs: load_addr <= axi_req.wdata[addr_w-1:0];
          reg_imem_data_ofs: begin
            if (!run) begin
              imem_we   <= 1'b1;
              load_addr <= load_addr + 1'b1;
            end
          end
          default: ;
        endcase
      end
      // Halt wins over a host write in the same cycle
      if (halt_event) begin
        run       <= 1'b0;
        halted    <= 1'b1;
        halt_pc_q <= halt_pc;
      end
    end
  end

  // Memory write payload, lands one cycle after the handshake
  always_ff @(posedge clk_n) begin
    if (wr_fire && axi_req.awaddr == reg_imem_data_ofs) begin
      imem_waddr <= load_addr;
      imem_wdata <= axi_req.wdata[inst_w-1:0];
    end
  end

  // GPR window starts at the base offset, one word per register
  assign gpr_ofs = axi_req.araddr - reg_gpr_base_ofs;
  assign gpr_sel = gpr_ofs[sel_w+1:2];
  assign gpr_hit = axi_req.araddr >= reg_gpr_base_ofs &&
                   axi_req.araddr <= reg_gpr_last_ofs &&
                   axi_req.araddr[1:0] == 2'b00;

  always_comb begin
    rd_mux = '0;
    if (gpr_hit) begin
      rd_mux[data_w-1:0] = gpr_data;
    end else begin
      case (axi_req.araddr)
        reg_ctrl_ofs: rd_mux[0] = run;
        reg_status_ofs: begin
          rd_mux[0]                       = halted;
          rd_mux[halt_pc_lsb +: addr_w]   = halt_pc_q;
        end
        reg_imem_addr_ofs: rd_mux[addr_w-1:0] = load_addr;
        default: ;  // Unmapped and write-only read 0
      endcase
    end
  end

  // Read handshake
  always_ff @(posedge clk_n) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      ar_ready <= axi_req.arvalid && !r_valid && !ar_ready;
      if (rd_fire)
        r_valid <= 1'b1;
      else if (axi_req.rready)
        r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_n) begin
    if (rd_fire)
      r_data <= rd_mux;
  end

  always_comb begin
    axi_rsp.awready = aw_ready;
    axi_rsp.wready  = aw_ready;
    axi_rsp.bvalid  = b_valid;
    axi_rsp.bresp   = resp_okay;
    axi_rsp.arready = ar_ready;
    axi_rsp.rdata   = r_data;
    axi_rsp.rresp   = resp_okay;
    axi_rsp.rvalid  = r_valid;
  end

endmodule

// File: instruction_fetch.sv
/* Program counter; held at 0 while stopped, wraps from 127 to 0
   A branch redirect takes effect on the next edge */
module instruction_fetch
  import cpu_pkg::*;
(
  input  logic              clk_n,
  input  logic              reset,
  input  logic              run,
  input  logic              branch_en,
  input  logic [addr_w-1:0] branch_addr,
  output logic [addr_w-1:0] pc
);

  logic [addr_w-1:0] pc_next;

  always_comb begin
    if (!run)
      pc_next = '0;  // Every run starts at address 0
    else if (branch_en)
      pc_next = branch_addr;
    else
      pc_next = pc + 1'b1;  // Natural wrap at addr_w bits
  end

  always_ff @(posedge clk_n) begin
    if (reset)
      pc <= '0;
    else
      pc <= pc_next;
  end

endmodule

// File: inst_mem.sv
/* 128 x 16 instruction store, combinational read, synchronous host write
   Contents are undefined until loaded */
module inst_mem
  import cpu_pkg::*;
(
  input  logic              clk_n,
  input  logic [addr_w-1:0] pc,
  input  logic              we,
  input  logic [addr_w-1:0] waddr,
  input  logic [inst_w-1:0] wdata,
  output logic [inst_w-1:0] curr_inst
);

  logic [inst_w-1:0] mem [imem_depth];

  always_ff @(posedge clk_n) begin
    if (we)
      mem[waddr] <= wdata;
  end

  assign curr_inst = mem[pc];  // Same-cycle fetch

endmodule

// File: execute_unit.sv
/* Single-cycle decode, register file, ALU and branch resolution
   Registers keep their values across runs; only reset clears them */
module execute_unit
  import cpu_pkg::*;
(
  input  logic              clk_n,
  input  logic              reset,
  input  logic              run,
  input  logic [addr_w-1:0] pc,
  input  logic [inst_w-1:0] curr_inst,
  input  logic [sel_w-1:0]  gpr_sel,
  output logic [data_w-1:0] gpr_data,
  output logic              branch_en,
  output logic [addr_w-1:0] branch_addr,
  output logic              halt_event,
  output logic [addr_w-1:0] halt_pc
);

  opcode_t           op;
  logic [sel_w-1:0]  rd_idx;
  logic [sel_w-1:0]  rs_idx;
  logic [data_w-1:0] rd_val;
  logic [data_w-1:0] rs_val;
  logic [data_w-1:0] alu_res;
  logic              wr_en;
  logic [data_w-1:0] regs [num_regs];

  // Instruction fields
  assign op     = opcode_t'(curr_inst[15:12]);
  assign rd_idx = curr_inst[11:9];
  assign rs_idx = curr_inst[8:6];

  assign rd_val = regs[rd_idx];
  assign rs_val = regs[rs_idx];

  always_comb begin
    alu_res = rd_val;
    wr_en   = 1'b0;
    case (op)
      op_ldi: begin
        alu_res = data_w'(curr_inst[8:0]);
        wr_en   = 1'b1;
      end
      op_add: begin
        alu_res = rd_val + rs_val;  // Wraps mod 2^16
        wr_en   = 1'b1;
      end
      op_sub: begin
        alu_res = rd_val - rs_val;
        wr_en   = 1'b1;
      end
      op_and: begin
        alu_res = rd_val & rs_val;
        wr_en   = 1'b1;
      end
      op_or: begin
        alu_res = rd_val | rs_val;
        wr_en   = 1'b1;
      end
      op_xor: begin
        alu_res = rd_val ^ rs_val;
        wr_en   = 1'b1;
      end
      default: ;  // nop, jmp, bz, halt and unused codes
    endcase
  end

  // Branch resolves in the same cycle
  assign branch_en   = run && (op == op_jmp || (op == op_bz && rd_val == '0));
  assign branch_addr = curr_inst[addr_w-1:0];

  assign halt_event = run && op == op_halt;
  assign halt_pc    = pc;  // Sampled by the register block on halt_event

  always_ff @(posedge clk_n) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end else if (run && wr_en) begin
      regs[rd_idx] <= alu_res;
    end
  end

  // Host readback port
  assign gpr_data = regs[gpr_sel];

endmodule

// File: cpu_top.sv
/* Core top level; the host controls everything through the AXI4-Lite port
   No interrupts, no data memory */
module cpu_top
  import cpu_pkg::*;
(
  input  logic          clk_n,
  input  logic          reset,
  input  axi_lite_req_t axi_req,
  output axi_lite_rsp_t axi_rsp
);

  logic              run;
  logic              imem_we;
  logic [addr_w-1:0] imem_waddr;
  logic [inst_w-1:0] imem_wdata;
  logic [sel_w-1:0]  gpr_sel;
  logic [data_w-1:0] gpr_data;
  logic              halt_event;
  logic [addr_w-1:0] halt_pc;
  logic              branch_en;
  logic [addr_w-1:0] branch_addr;
  logic [addr_w-1:0] pc;
  logic [inst_w-1:0] curr_inst;

  axi_lite_regs regs_inst (
    .clk_n      (clk_n),
    .reset      (reset),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp),
    .halt_event (halt_event),
    .halt_pc    (halt_pc),
    .gpr_data   (gpr_data),
    .run        (run),
    .imem_we    (imem_we),
    .imem_waddr (imem_waddr),
    .imem_wdata (imem_wdata),
    .gpr_sel    (gpr_sel)
  );

  instruction_fetch fetch_inst (
    .clk_n       (clk_n),
    .reset       (reset),
    .run         (run),
    .branch_en   (branch_en),
    .branch_addr (branch_addr),
    .pc          (pc)
  );

  inst_mem imem_inst (
    .clk_n     (clk_n),
    .pc        (pc),
    .we        (imem_we),
    .waddr     (imem_waddr),
    .wdata     (imem_wdata),
    .curr_inst (curr_inst)
  );

  execute_unit exec_inst (
    .clk_n       (clk_n),
    .reset       (reset),
    .run         (run),
    .pc          (pc),
    .curr_inst   (curr_inst),
    .gpr_sel     (gpr_sel),
    .gpr_data    (gpr_data),
    .branch_en   (branch_en),
    .branch_addr (branch_addr),
    .halt_event  (halt_event),
    .halt_pc     (halt_pc)
  );

endmodule

// File: tb_cpu_top.sv
/* Table-driven testbench for cpu_top; each program is 8 words loaded at address 0
   A halt word is parked at address 127 for the jump test and registers persist between runs */
module tb_cpu_top
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [0:7][inst_w-1:0] prog_t;  // Word 0 is leftmost

  typedef struct {
    string             name;
    prog_t             prog;
    int                reg_idx;
    logic [data_w-1:0] exp_val;
    int                exp_pc;
  } test_t;

  logic          clk_n = 1'b0;
  logic          reset;
  axi_lite_req_t axi_req;
  axi_lite_rsp_t axi_rsp;
  test_t         tests[$];
  int            error_count = 0;
  int            check_count = 0;
  int            cycle_count = 0;
  int            max_cycles = 2000;

  cpu_top cpu_top_inst (
    .clk_n   (clk_n),
    .reset   (reset),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp)
  );

  always #50 clk_n = ~clk_n;

  // Run limit from the table length
  always @(posedge clk_n) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Run stopped after %0d cycles before all tests finished", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Instruction encoders with the ISA field layout
  function automatic logic [inst_w-1:0] ldi_word(int rd, int imm);
    return {op_ldi, 3'(rd), 9'(imm)};
  endfunction

  function automatic logic [inst_w-1:0] alu_word(opcode_t op, int rd, int rs);
    return {op, 3'(rd), 3'(rs), 6'h00};
  endfunction

  function automatic logic [inst_w-1:0] branch_word(opcode_t op, int rd, int target);
    return {op, 3'(rd), 2'b00, 7'(target)};
  endfunction

  function automatic test_t make_test(string name, prog_t prog, int reg_idx,
                                      logic [data_w-1:0] exp_val, int exp_pc);
    test_t t;
    t.name    = name;
    t.prog    = prog;
    t.reg_idx = reg_idx;
    t.exp_val = exp_val;
    t.exp_pc  = exp_pc;
    return t;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic write_reg(input logic [axi_addr_w-1:0] addr, input logic [31:0] data);
    int delay;
    delay = $urandom % 4;  // Random bready stall
    @(posedge clk_n);
    axi_req.awaddr  <= addr;
    axi_req.awvalid <= 1'b1;
    axi_req.wdata   <= data;
    axi_req.wstrb   <= 4'hf;
    axi_req.wvalid  <= 1'b1;
    do @(posedge clk_n); while (!axi_rsp.awready);
    check_value($sformatf("write 0x%02h wready", addr), 32'd1, 32'(axi_rsp.wready));
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    do @(posedge clk_n); while (!axi_rsp.bvalid);
    check_value($sformatf("write 0x%02h bresp", addr), 32'd0, 32'(axi_rsp.bresp));  // OKAY
    repeat (delay) @(posedge clk_n);
    axi_req.bready <= 1'b1;
    @(posedge clk_n);
    axi_req.bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [axi_addr_w-1:0] addr, output logic [31:0] data);
    int delay;
    delay = $urandom % 4;  // Random rready stall
    @(posedge clk_n);
    axi_req.araddr  <= addr;
    axi_req.arvalid <= 1'b1;
    do @(posedge clk_n); while (!axi_rsp.arready);
    axi_req.arvalid <= 1'b0;
    do @(posedge clk_n); while (!axi_rsp.rvalid);
    data = axi_rsp.rdata;
    check_value($sformatf("read 0x%02h rresp", addr), 32'd0, 32'(axi_rsp.rresp));  // OKAY
    repeat (delay) @(posedge clk_n);
    axi_req.rready <= 1'b1;
    @(posedge clk_n);
    axi_req.rready <= 1'b0;
  endtask

  task automatic load_program(input prog_t prog);
    write_reg(reg_imem_addr_ofs, 32'd0);
    for (int i = 0; i < 8; i++)
      write_reg(reg_imem_data_ofs, {16'h0000, prog[i]});
  endtask

  task automatic poll_halt(input string name, output logic [31:0] status, output bit done);
    done = 1'b0;
    for (int n = 0; n < 50 && !done; n++) begin
      read_reg(reg_status_ofs, status);
      done = status[0];
    end
    if (!done) begin
      error_count++;
      $display("Timeout: %s did not halt within 50 STATUS reads", name);
      write_reg(reg_ctrl_ofs, 32'd0);  // Stop the core for the next test
    end
  endtask

  task automatic run_test(input test_t t);
    logic [31:0] data;
    logic [31:0] status;
    bit          done;
    load_program(t.prog);
    read_reg(reg_imem_addr_ofs, data);
    check_value({t.name, " imem_addr"}, 32'd8, data);
    write_reg(reg_ctrl_ofs, 32'd1);
    poll_halt(t.name, status, done);
    if (done) begin
      check_value({t.name, " halt_pc"}, 32'(t.exp_pc), 32'(status[14:8]));
      read_reg(reg_ctrl_ofs, data);
      check_value({t.name, " ctrl"}, 32'd0, data);
      read_reg(8'(reg_gpr_base_ofs + 4 * t.reg_idx), data);
      check_value({t.name, " register"}, 32'(t.exp_val), data);
    end
  endtask

  initial begin
    logic [31:0]       data;
    logic [inst_w-1:0] hlt;
    logic [inst_w-1:0] nop;
    hlt = alu_word(op_halt, 0, 0);
    nop = alu_word(op_nop, 0, 0);
    void'($urandom(28));
    reset   <= 1'b1;
    axi_req <= '0;
    tests.push_back(make_test("alu_ldi_add", {ldi_word(1, 100), ldi_word(2, 23),
      alu_word(op_add, 1, 2), hlt, nop, nop, nop, nop}, 1, 16'd123, 3));
    tests.push_back(make_test("alu_sub_wrap", {ldi_word(3, 5), ldi_word(4, 7),
      alu_word(op_sub, 3, 4), hlt, nop, nop, nop, nop}, 3, 16'hfffe, 3));
    tests.push_back(make_test("alu_and", {ldi_word(5, 'h1f0), ldi_word(6, 'h0ff),
      alu_word(op_and, 5, 6), hlt, nop, nop, nop, nop}, 5, 16'h00f0, 3));
    tests.push_back(make_test("alu_or_xor", {ldi_word(1, 'h0f0), ldi_word(2, 'h00f),
      alu_word(op_or, 1, 2), ldi_word(2, 'h1ff), alu_word(op_xor, 1, 2), hlt, nop, nop},
      1, 16'h0100, 5));
    tests.push_back(make_test("bz_taken", {ldi_word(7, 0), branch_word(op_bz, 7, 3),
      ldi_word(7, 'h55), hlt, nop, nop, nop, nop}, 7, 16'h0000, 3));
    tests.push_back(make_test("bz_not_taken", {ldi_word(6, 1), branch_word(op_bz, 6, 4),
      ldi_word(6, 'h42), hlt, hlt, nop, nop, nop}, 6, 16'h0042, 3));
    tests.push_back(make_test("jmp_to_127", {ldi_word(0, 9), branch_word(op_jmp, 0, 127),
      ldi_word(0, 0), hlt, nop, nop, nop, nop}, 0, 16'd9, 127));
    // r1 still holds 0x100 from alu_or_xor
    tests.push_back(make_test("restart_keeps_regs", {alu_word(op_add, 1, 1), hlt,
      nop, nop, nop, nop, nop, nop}, 1, 16'h0200, 1));
    max_cycles = tests.size() * 400 + 2000;

    repeat (2) @(posedge clk_n);
    reset <= 1'b0;

    read_reg(reg_ctrl_ofs, data);
    check_value("ctrl_after_reset", 32'd0, data);
    write_reg(reg_imem_addr_ofs, 32'd127);
    write_reg(reg_imem_data_ofs, {16'h0000, hlt});
    read_reg(reg_imem_addr_ofs, data);
    check_value("imem_addr_wrap", 32'd0, data);  // 127 + 1 wraps

    foreach (tests[i])
      run_test(tests[i]);

    // Status, load address and registers are nonzero here
    read_reg(8'h40, data);
    check_value("unmapped_read", 32'd0, data);

    // Endless loop at 0 and a load attempt while it runs
    write_reg(reg_imem_addr_ofs, 32'd0);
    write_reg(reg_imem_data_ofs, {16'h0000, branch_word(op_jmp, 0, 0)});
    write_reg(reg_ctrl_ofs, 32'd1);
    read_reg(reg_status_ofs, data);
    check_value("load_while_running halted", 32'd0, 32'(data[0]));
    write_reg(reg_imem_data_ofs, {16'h0000, hlt});
    read_reg(reg_imem_addr_ofs, data);
    check_value("load_while_running imem_addr", 32'd1, data);
    read_reg(reg_ctrl_ofs, data);
    check_value("load_while_running ctrl", 32'd1, data);
    write_reg(reg_ctrl_ofs, 32'd0);

    $display("Tests: %0d, checks: %0d, errors: %0d", tests.size(), check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
cpu_pkg.sv
axi_lite_regs.sv
instruction_fetch.sv
inst_mem.sv
execute_unit.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator, exit 1 on any failure
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_cpu_top -o tb_cpu_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
  echo "Failures found in $log"
  exit 1
fi
exit 0
